/* common/sd_dma_pkg.sv */
// shared types for the sd dma engine; block length must be a power of two, burst mode absent
`default_nettype none

package sd_dma_pkg;

	////////////////////////////////////////////////////////////
	// widths and sizes

	localparam int DMA_ADDR_W  = 21;                   // sound cpu memory space
	localparam int BLOCK_BYTES = 512;                  // one sd sector
	localparam int FIFO_AW     = $clog2(BLOCK_BYTES);  // fifo array address bits

	typedef logic [7:0]            byte_t;      // data on every bus
	typedef logic [DMA_ADDR_W-1:0] dma_addr_t;  // memory byte address
	typedef logic [FIFO_AW:0]      fifo_ptr_t;  // msb set once a whole block is done
	typedef logic [1:0]            regsel_t;    // ports bus register select

	////////////////////////////////////////////////////////////
	// register map

	localparam regsel_t REG_HAD = 2'd0;  // address bits 20..16
	localparam regsel_t REG_MAD = 2'd1;  // address bits 15..8
	localparam regsel_t REG_LAD = 2'd2;  // address bits 7..0
	localparam regsel_t REG_CST = 2'd3;  // control and status

	localparam int CST_RUN_BIT = 7;  // write 1 starts a block, self clears
	localparam int CST_SNR_BIT = 0;  // 1 send to card, 0 receive from card

	////////////////////////////////////////////////////////////
	// fsm states

	typedef enum logic [2:0] {
		SD_IDLE,
		SD_READ_WAIT,   // waiting on card ready
		SD_READ_STB,    // start exchange, store byte
		SD_WRITE_WAIT,  // waiting on card ready and fifo data
		SD_WRITE_STB    // start exchange, pop byte
	} sd_state_t;

	typedef enum logic [2:0] {
		DMA_IDLE,
		DMA_PUT_WAIT,  // fifo empty, nothing to put
		DMA_PUT_RUN,   // request out, waiting on ack
		DMA_GET_WAIT,  // request out, waiting on ack
		DMA_GET_RUN    // acked, waiting on end
	} dma_state_t;

	typedef struct packed {
		logic go;   // one cycle, together with fifo init
		logic snr;  // direction level
	} xfer_ctrl_t;

	typedef struct packed {
		logic wdone;  // all block bytes written
		logic rdone;  // all block bytes read
		logic empty;  // pointers equal
	} fifo_stat_t;

endpackage

`default_nettype wire

/* fifo/fifo512_oneshot.sv */
// one-shot block fifo; needs init before every block, rd_stb while empty or wr_stb after wdone desync it
`timescale 1ns/1ps
`default_nettype none

module fifo512_oneshot
	import sd_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       init,    // both pointers back to zero
	input  logic       wr_stb,  // store wd, advance write pointer
	input  logic       rd_stb,  // advance read pointer
	input  byte_t      wd,
	output byte_t      rd,      // byte at read pointer
	output fifo_stat_t stat
);

	byte_t     mem [BLOCK_BYTES];  // sector buffer
	fifo_ptr_t wptr;
	fifo_ptr_t rptr;

	////////////////////////////////////////////////////////////
	// pointers

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else
		begin
			if (init)
				wptr <= '0;
			else if (wr_stb)
				wptr <= wptr + 1'b1;

			if (init)
				rptr <= '0;
			else if (rd_stb)
				rptr <= rptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (wr_stb)
			mem[wptr[FIFO_AW-1:0]] <= wd;
	end

	assign rd = mem[rptr[FIFO_AW-1:0]];  // combinational read, valid while not empty

	assign stat.wdone = wptr[FIFO_AW];  // pointer wrapped past the last entry
	assign stat.rdone = rptr[FIFO_AW];
	assign stat.empty = (wptr == rptr);

endmodule

`default_nettype wire

/* src/sd_xfer_fsm.sv */
// sd side sequencer; two cycles per byte at best, sd_rdy must drop on the edge after sd_start
`timescale 1ns/1ps
`default_nettype none

module sd_xfer_fsm
	import sd_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  xfer_ctrl_t xfer_ctrl,
	input  fifo_stat_t fifo_stat,
	input  logic       sd_rdy,
	output logic       sd_start,
	output logic       sd_override,
	output logic       fifo_wr_stb,
	output logic       fifo_rd_stb,
	output logic       sd_idle
);

	sd_state_t state;
	sd_state_t next_state;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SD_IDLE;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		next_state = state;  // hold by default
		case (state)
		SD_IDLE:
		begin
			if (xfer_ctrl.go)
				next_state = xfer_ctrl.snr ? SD_WRITE_WAIT : SD_READ_WAIT;
		end
		SD_READ_WAIT:
		begin
			if (fifo_stat.wdone)
				next_state = SD_IDLE;       // whole block stored
			else if (sd_rdy)
				next_state = SD_READ_STB;   // card free, kick next exchange
		end
		SD_READ_STB:
		begin
			next_state = SD_READ_WAIT;
		end
		SD_WRITE_WAIT:
		begin
			if (fifo_stat.rdone)
				next_state = SD_IDLE;       // whole block sent
			else if (sd_rdy && !fifo_stat.empty)
				next_state = SD_WRITE_STB;  // card free and a byte is waiting
		end
		SD_WRITE_STB:
		begin
			next_state = SD_WRITE_WAIT;
		end
		default:
		begin
			next_state = SD_IDLE;
		end
		endcase
	end

	////////////////////////////////////////////////////////////
	// outputs, decoded from state

	assign sd_idle     = (state == SD_IDLE);
	assign sd_override = !sd_idle;  // own the spi module for the whole block
	assign sd_start    = (state == SD_READ_STB) || (state == SD_WRITE_STB);
	assign fifo_wr_stb = (state == SD_READ_STB);   // last received byte into fifo
	assign fifo_rd_stb = (state == SD_WRITE_STB);  // byte on sd_datatosend, pop it

endmodule

`default_nettype wire

/* src/dma_xfer_fsm.sv */
// dma side sequencer; one request outstanding, dma_end must come at least a cycle after dma_ack
`timescale 1ns/1ps
`default_nettype none

module dma_xfer_fsm
	import sd_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  xfer_ctrl_t xfer_ctrl,
	input  fifo_stat_t fifo_stat,
	input  logic       dma_ack,
	input  logic       dma_end,
	output logic       dma_req,
	output logic       dma_rnw,
	output logic       fifo_wr_stb,
	output logic       fifo_rd_stb,
	output logic       dma_idle
);

	dma_state_t state;
	dma_state_t next_state;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= DMA_IDLE;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		next_state = state;
		case (state)
		DMA_IDLE:
		begin
			if (xfer_ctrl.go)
				next_state = xfer_ctrl.snr ? DMA_GET_WAIT : DMA_PUT_WAIT;
		end
		DMA_PUT_WAIT:
		begin
			if (fifo_stat.rdone)
				next_state = DMA_IDLE;      // block drained to memory
			else if (!fifo_stat.empty)
				next_state = DMA_PUT_RUN;   // card byte available
		end
		DMA_PUT_RUN:
		begin
			if (dma_ack)
				next_state = DMA_PUT_WAIT;  // byte taken, recheck fifo
		end
		DMA_GET_WAIT:
		begin
			if (fifo_stat.wdone)
				next_state = DMA_IDLE;      // block fetched
			else if (dma_ack)
				next_state = DMA_GET_RUN;
		end
		DMA_GET_RUN:
		begin
			if (dma_end)
				next_state = DMA_GET_WAIT;  // read data landed in fifo
		end
		default:
		begin
			next_state = DMA_IDLE;
		end
		endcase
	end

	////////////////////////////////////////////////////////////
	// outputs

	assign dma_idle    = (state == DMA_IDLE);
	assign dma_rnw     = (state == DMA_GET_WAIT) || (state == DMA_GET_RUN);  // low in receive
	assign dma_req     = (state == DMA_PUT_RUN)
	                   || ((state == DMA_GET_WAIT) && !fifo_stat.wdone);     // drops after last ack
	assign fifo_rd_stb = (state == DMA_PUT_RUN) && dma_ack;  // memory samples dma_wd at ack
	assign fifo_wr_stb = (state == DMA_GET_RUN) && dma_end;  // dma_rd valid at end

endmodule

`default_nettype wire

/* src/sd_dma_regs.sv */
// address and control registers; writing run while a block is active restarts the fifo mid block
`timescale 1ns/1ps
`default_nettype none

module sd_dma_regs
	import sd_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  byte_t      din,
	output byte_t      dout,
	input  logic       module_select,
	input  logic       write_strobe,
	input  regsel_t    regsel,
	input  logic       dma_ack,
	input  logic       sd_idle,
	input  logic       dma_idle,
	input  fifo_stat_t fifo_stat,
	output dma_addr_t  dma_addr,
	output xfer_ctrl_t xfer_ctrl,
	output logic       fifo_init
);

	logic cst_run;   // block in progress
	logic cst_snr;   // direction
	logic port_wr;
	logic cst_wr;
	logic start;
	logic finish;

	assign port_wr = module_select && write_strobe;
	assign cst_wr  = port_wr && (regsel == REG_CST);
	assign start   = cst_wr && din[CST_RUN_BIT];

	// stale rdone from the last block is still visible during the init cycle
	assign finish  = cst_run && !fifo_init && fifo_stat.rdone && sd_idle && dma_idle;

	assign xfer_ctrl.go  = fifo_init;  // same cycle as fifo clear
	assign xfer_ctrl.snr = cst_snr;

	////////////////////////////////////////////////////////////
	// control and status

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cst_run   <= 1'b0;
			cst_snr   <= 1'b0;  // receive, leaves card contents alone
			fifo_init <= 1'b0;
		end
		else
		begin
			fifo_init <= start;  // one cycle after the write strobe
			if (cst_wr)
			begin
				cst_run <= din[CST_RUN_BIT];
				cst_snr <= din[CST_SNR_BIT];  // burst bit dropped
			end
			else if (finish)
				cst_run <= 1'b0;  // self clear at block end
		end
	end

	////////////////////////////////////////////////////////////
	// address counter

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dma_addr <= '0;
		else if (dma_ack && cst_run)
			dma_addr <= dma_addr + 1'b1;  // one byte per ack
		else if (port_wr && (regsel == REG_HAD))
			dma_addr[DMA_ADDR_W-1:16] <= din[DMA_ADDR_W-17:0];  // upper din bits dropped
		else if (port_wr && (regsel == REG_MAD))
			dma_addr[15:8] <= din;
		else if (port_wr && (regsel == REG_LAD))
			dma_addr[7:0] <= din;
	end

	// readback, unused bits as zero
	always_comb
	begin
		dout = '0;
		case (regsel)
		REG_HAD: dout = byte_t'(dma_addr[DMA_ADDR_W-1:16]);
		REG_MAD: dout = dma_addr[15:8];
		REG_LAD: dout = dma_addr[7:0];
		REG_CST:
		begin
			dout[CST_RUN_BIT] = cst_run;
			dout[CST_SNR_BIT] = cst_snr;
		end
		endcase
	end

endmodule

`default_nettype wire

/* src/sd_dma_top.sv */
// sd card dma top; sd_rdy must fall on the edge that samples sd_start, dma_end at least a cycle after dma_ack
`timescale 1ns/1ps
`default_nettype none

module sd_dma_top
	import sd_dma_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// sd spi module
	output logic      sd_start,
	input  logic      sd_rdy,
	input  byte_t     sd_receiveddata,
	output byte_t     sd_datatosend,
	output logic      sd_override,      // takes the spi module away from the cpu

	// ports bus
	input  byte_t     din,
	output byte_t     dout,
	input  logic      module_select,
	input  logic      write_strobe,
	input  regsel_t   regsel,

	// dma sequencer
	output dma_addr_t dma_addr,
	output byte_t     dma_wd,
	input  byte_t     dma_rd,
	output logic      dma_rnw,
	output logic      dma_req,
	input  logic      dma_ack,
	input  logic      dma_end
);

	xfer_ctrl_t xfer_ctrl;    // go pulse and direction
	fifo_stat_t fifo_stat;
	logic       fifo_init;
	logic       sd_idle;
	logic       dma_idle;

	logic       sd_wr_stb;    // receive side fifo push
	logic       sd_rd_stb;    // send side fifo pop
	logic       dma_wr_stb;   // send side fifo push
	logic       dma_rd_stb;   // receive side fifo pop
	logic       fifo_wr_stb;
	logic       fifo_rd_stb;
	byte_t      fifo_wd;
	byte_t      fifo_rd;

	////////////////////////////////////////////////////////////
	// data steering

	assign fifo_wr_stb   = sd_wr_stb | dma_wr_stb;  // only one side active per direction
	assign fifo_rd_stb   = sd_rd_stb | dma_rd_stb;

	assign fifo_wd       = xfer_ctrl.snr ? dma_rd  : sd_receiveddata;
	assign sd_datatosend = xfer_ctrl.snr ? fifo_rd : 8'hff;  // idle ones while reading the card
	assign dma_wd        = fifo_rd;                          // memory only ever takes fifo data

	////////////////////////////////////////////////////////////
	// blocks

	sd_dma_regs u_regs (
		.clk           (clk),
		.rst_n         (rst_n),
		.din           (din),
		.dout          (dout),
		.module_select (module_select),
		.write_strobe  (write_strobe),
		.regsel        (regsel),
		.dma_ack       (dma_ack),
		.sd_idle       (sd_idle),
		.dma_idle      (dma_idle),
		.fifo_stat     (fifo_stat),
		.dma_addr      (dma_addr),
		.xfer_ctrl     (xfer_ctrl),
		.fifo_init     (fifo_init)
	);

	fifo512_oneshot u_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.init   (fifo_init),
		.wr_stb (fifo_wr_stb),
		.rd_stb (fifo_rd_stb),
		.wd     (fifo_wd),
		.rd     (fifo_rd),
		.stat   (fifo_stat)
	);

	sd_xfer_fsm u_sd_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.xfer_ctrl   (xfer_ctrl),
		.fifo_stat   (fifo_stat),
		.sd_rdy      (sd_rdy),
		.sd_start    (sd_start),
		.sd_override (sd_override),
		.fifo_wr_stb (sd_wr_stb),
		.fifo_rd_stb (sd_rd_stb),
		.sd_idle     (sd_idle)
	);

	dma_xfer_fsm u_dma_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.xfer_ctrl   (xfer_ctrl),
		.fifo_stat   (fifo_stat),
		.dma_ack     (dma_ack),
		.dma_end     (dma_end),
		.dma_req     (dma_req),
		.dma_rnw     (dma_rnw),
		.fifo_wr_stb (dma_wr_stb),
		.fifo_rd_stb (dma_rd_stb),
		.dma_idle    (dma_idle)
	);

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// free running 10 ns clock; rst_n held low for the first 5 rising edges, then released for good
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
	output logic clk,
	output logic rst_n
);

	localparam int RESET_CYCLES = 5;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;  // release on an edge, seen by the DUT one cycle later
	end

endmodule

`default_nettype wire

/* verif/tb_sd_dma.sv */
// testbench; test list from verif/sd_dma_golden.hex (run from project root), at most 16 tests
`timescale 1ns/1ps
`default_nettype none

module tb_sd_dma
	import sd_dma_pkg::*;
();

	localparam int MAX_TESTS       = 16;
	localparam int CYCLES_PER_BYTE = 200;   // watchdog allowance
	localparam int SETUP_CYCLES    = 2000;  // reset and register checks

	logic      clk;
	logic      rst_n;
	logic      sd_start;
	logic      sd_rdy = 1'b1;
	byte_t     sd_receiveddata = '0;
	byte_t     sd_datatosend;
	logic      sd_override;
	byte_t     din;
	byte_t     dout;
	logic      module_select;
	logic      write_strobe;
	regsel_t   regsel;
	dma_addr_t dma_addr;
	byte_t     dma_wd;
	byte_t     dma_rd = '0;
	logic      dma_rnw;
	logic      dma_req;
	logic      dma_ack = 1'b0;
	logic      dma_end = 1'b0;

	logic [31:0] golden [0:4*MAX_TESTS-1];  // dir, start, seed, end
	int          num_tests;
	logic        tests_ready;
	int          checks;
	int          errors;

	int          test_num;   // bumped per test, models restart on change
	logic [31:0] cur_seed;
	logic        cur_dir;

	int          sd_loaded = -1;
	logic [31:0] sd_gen;                // card data stream
	logic [31:0] sd_rng = 32'h6f5b;     // ready delays
	int          sd_wait;
	int          sd_count;              // start pulses seen
	int          override_drop;
	byte_t       sd_sent [BLOCK_BYTES];

	int          mem_loaded = -1;
	logic [31:0] mem_gen;               // memory read data stream
	logic [31:0] mem_rng = 32'h6f5b;    // ack delays
	int          mem_phase;
	int          mem_wait;
	int          wr_count;
	int          rd_count;
	int          rnw_bad;
	dma_addr_t   wr_addr [BLOCK_BYTES];
	byte_t       wr_data [BLOCK_BYTES];
	dma_addr_t   rd_addr [BLOCK_BYTES];

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	sd_dma_top u_sd_dma_top (
		.clk             (clk),
		.rst_n           (rst_n),
		.sd_start        (sd_start),
		.sd_rdy          (sd_rdy),
		.sd_receiveddata (sd_receiveddata),
		.sd_datatosend   (sd_datatosend),
		.sd_override     (sd_override),
		.din             (din),
		.dout            (dout),
		.module_select   (module_select),
		.write_strobe    (write_strobe),
		.regsel          (regsel),
		.dma_addr        (dma_addr),
		.dma_wd          (dma_wd),
		.dma_rd          (dma_rd),
		.dma_rnw         (dma_rnw),
		.dma_req         (dma_req),
		.dma_ack         (dma_ack),
		.dma_end         (dma_end)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
	                           input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("FAIL t=%0t %s: got %0h expected %0h", $time, what, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// ports bus access

	task automatic reg_write(input regsel_t sel, input byte_t val);
		@(posedge clk);
		module_select <= 1'b1;
		write_strobe  <= 1'b1;
		regsel        <= sel;
		din           <= val;
		@(posedge clk);
		module_select <= 1'b0;
		write_strobe  <= 1'b0;
	endtask

	task automatic reg_read(input regsel_t sel, output byte_t val);
		@(posedge clk);
		regsel <= sel;
		@(negedge clk);
		val = dout;  // readback mux settled
	endtask

	task automatic read_addr(output dma_addr_t addr);
		byte_t h;
		byte_t m;
		byte_t l;
		reg_read(REG_HAD, h);
		reg_read(REG_MAD, m);
		reg_read(REG_LAD, l);
		addr = {h[DMA_ADDR_W-17:0], m, l};
	endtask

	////////////////////////////////////////////////////////////
	// sd card model

	always @(posedge clk)
	begin
		if (!rst_n)
			sd_rdy <= 1'b1;
		else if (sd_loaded != test_num)
		begin
			sd_loaded = test_num;              // new test, restart stream
			sd_gen    = xorshift32(cur_seed);
			sd_receiveddata <= sd_gen[7:0];    // first byte ready before any start
			sd_count      = 0;
			override_drop = 0;
		end
		else
		begin
			if (sd_count > 0 && sd_count < BLOCK_BYTES && !sd_override)
				override_drop++;               // bus lost mid block
			if (sd_start)
			begin
				if (sd_count < BLOCK_BYTES)
					sd_sent[sd_count] = sd_datatosend;
				sd_count++;
				sd_gen = xorshift32(sd_gen);
				sd_receiveddata <= sd_gen[7:0];
				sd_rng  = xorshift32(sd_rng);
				sd_wait = int'(sd_rng[3:0]);   // busy 1 to 16 cycles
				sd_rdy <= 1'b0;                // falls on the start edge
			end
			else if (!sd_rdy)
			begin
				if (sd_wait == 0)
					sd_rdy <= 1'b1;
				else
					sd_wait--;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// memory model

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			dma_ack  <= 1'b0;
			dma_end  <= 1'b0;
			mem_phase = 0;
		end
		else if (mem_loaded != test_num)
		begin
			mem_loaded = test_num;
			mem_gen  = cur_seed;
			wr_count = 0;
			rd_count = 0;
			rnw_bad  = 0;
		end
		else
		begin
			if (!cur_dir && dma_rnw)
				rnw_bad++;                     // read cycle during receive
			case (mem_phase)
			0:
			begin
				if (dma_req && mem_wait == 0)
				begin
					dma_ack  <= 1'b1;
					mem_phase = 1;
				end
				else if (dma_req)
					mem_wait--;
			end
			1:
			begin
				dma_ack <= 1'b0;               // DUT takes the ack on this edge
				dma_end <= 1'b1;
				if (dma_rnw)
				begin
					if (rd_count < BLOCK_BYTES)
						rd_addr[rd_count] = dma_addr;
					rd_count++;
					mem_gen = xorshift32(mem_gen);
					dma_rd <= mem_gen[7:0];    // valid with dma_end
				end
				else
				begin
					if (wr_count < BLOCK_BYTES)
					begin
						wr_addr[wr_count] = dma_addr;
						wr_data[wr_count] = dma_wd;
					end
					wr_count++;
				end
				mem_phase = 2;
			end
			default:
			begin
				dma_end <= 1'b0;
				mem_rng   = xorshift32(mem_rng);
				mem_wait  = int'(mem_rng[10:8]);  // next ack 0 to 7 cycles late
				mem_phase = 0;
			end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// test sequences

	task automatic check_reset_state();
		dma_addr_t addr;
		byte_t     cst;
		read_addr(addr);
		check_value(addr, 0, "address after reset");
		reg_read(REG_CST, cst);
		check_value(cst, 0, "control after reset");
		check_value(sd_override, 1'b0, "sd_override after reset");
		check_value(dma_req, 1'b0, "dma_req after reset");
		check_value(dma_rnw, 1'b0, "dma_rnw after reset");
		check_value(sd_start, 1'b0, "sd_start after reset");
	endtask

	task automatic check_register_access();
		byte_t val;
		reg_write(REG_HAD, 8'hff);
		reg_write(REG_MAD, 8'ha5);
		reg_write(REG_LAD, 8'h3c);
		reg_read(REG_HAD, val);
		check_value(val, 8'h1f, "high address, bits above 20 zero");
		reg_read(REG_MAD, val);
		check_value(val, 8'ha5, "middle address");
		reg_read(REG_LAD, val);
		check_value(val, 8'h3c, "low address");
		reg_write(REG_CST, 8'h7f);  // all but run, burst bit included
		reg_read(REG_CST, val);
		check_value(val, 8'h01, "control, only direction kept");
		reg_write(REG_CST, 8'h00);
		reg_read(REG_CST, val);
		check_value(val, 8'h00, "control cleared");
		check_value(sd_override, 1'b0, "sd_override without run");
		check_value(dma_req, 1'b0, "dma_req without run");
	endtask

	task automatic run_test(input int t);
		logic        dir;
		dma_addr_t   start;
		dma_addr_t   exp_end;
		dma_addr_t   addr;
		logic [31:0] seed;
		logic [31:0] gen;
		byte_t       cst;
		byte_t       exp_cst;
		dir     = golden[4*t][0];
		start   = golden[4*t+1][DMA_ADDR_W-1:0];
		seed    = golden[4*t+2];
		exp_end = golden[4*t+3][DMA_ADDR_W-1:0];
		$display("test %0d: %s start %h seed %h", t, dir ? "send" : "receive", start, seed);
		@(posedge clk);
		cur_dir  <= dir;
		cur_seed <= seed;
		test_num <= t + 1;
		reg_write(REG_HAD, byte_t'(start[DMA_ADDR_W-1:16]));
		reg_write(REG_MAD, start[15:8]);
		reg_write(REG_LAD, start[7:0]);
		read_addr(addr);
		check_value(addr, start, "start address readback");
		cst = '0;
		cst[CST_RUN_BIT] = 1'b1;
		cst[CST_SNR_BIT] = dir;
		reg_write(REG_CST, cst);
		reg_read(REG_CST, cst);
		while (cst[CST_RUN_BIT])  // watchdog bounds this
			reg_read(REG_CST, cst);
		exp_cst = '0;
		exp_cst[CST_SNR_BIT] = dir;
		check_value(cst, exp_cst, "control after block end");
		read_addr(addr);
		check_value(addr, exp_end, "end address");
		check_value(sd_override, 1'b0, "sd_override after block");
		check_value(dma_req, 1'b0, "dma_req after block");
		check_value(sd_count, BLOCK_BYTES, "sd start pulses");
		check_value(wr_count, dir ? 0 : BLOCK_BYTES, "memory writes");
		check_value(rd_count, dir ? BLOCK_BYTES : 0, "memory reads");
		check_value(rnw_bad, 0, "cycles with dma_rnw high in receive");
		check_value(override_drop, 0, "cycles with sd_override low mid block");
		gen = seed;
		for (int i = 0; i < BLOCK_BYTES; i++)
		begin
			gen = xorshift32(gen);  // byte i of the test stream
			if (dir)
			begin
				check_value(rd_addr[i], dma_addr_t'(start + i), $sformatf("read %0d addr", i));
				check_value(sd_sent[i], gen[7:0], $sformatf("sent byte %0d", i));
			end
			else
			begin
				check_value(wr_addr[i], dma_addr_t'(start + i), $sformatf("write %0d addr", i));
				check_value(wr_data[i], gen[7:0], $sformatf("write %0d data", i));
				check_value(sd_sent[i], 8'hff, $sformatf("idle byte %0d to card", i));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// main and watchdog

	initial
	begin
		din           = '0;
		module_select = 1'b0;
		write_strobe  = 1'b0;
		regsel        = REG_HAD;
		test_num      = 0;
		cur_seed      = '0;
		cur_dir       = 1'b0;
		checks        = 0;
		errors        = 0;
		tests_ready   = 1'b0;
		$readmemh("verif/sd_dma_golden.hex", golden);
		num_tests = 0;
		while (num_tests < MAX_TESTS && !$isunknown(golden[4*num_tests])
		       && golden[4*num_tests] != 32'hff)
			num_tests++;
		tests_ready = 1'b1;
		if (num_tests == 0)
		begin
			$display("no tests could be read from verif/sd_dma_golden.hex");
			errors++;
		end
		wait (rst_n === 1'b1);
		check_reset_state();
		check_register_access();
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		wait (tests_ready === 1'b1);
		limit = CYCLES_PER_BYTE * BLOCK_BYTES * num_tests + SETUP_CYCLES;
		repeat (limit) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/sd_dma_pkg.sv
fifo/fifo512_oneshot.sv
src/sd_xfer_fsm.sv
src/dma_xfer_fsm.sv
src/sd_dma_regs.sv
src/sd_dma_top.sv
verif/tb_clk_gen.sv
verif/tb_sd_dma.sv

/* Bender.yml */
package:
  name: sd_dma

sources:
  - common/sd_dma_pkg.sv
  - fifo/fifo512_oneshot.sv
  - src/sd_xfer_fsm.sv
  - src/dma_xfer_fsm.sv
  - src/sd_dma_regs.sv
  - src/sd_dma_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_sd_dma.sv

/* verif/sd_dma_golden.hex */
// columns: direction (0 receive, 1 send), start address, data seed, expected end address
// a direction of ff closes the list, at most 16 tests
0 000100 00001a2b 000300
1 000800 00003c4d 000a00
0 01f000 0000beef 01f200
1 123456 00c0ffee 123656
0 1ffe00 00005a5a 000000
1 0abcde 00777777 0abede
0 00ffff 13572468 0101ff
1 1fff80 0badcafe 000180
0 000000 00000001 000200
ff 000000 00000000 000000
